//--- all.f
+incdir+testbench
hw/frame_pkg.sv
hw/crc8_unit.sv
hw/cmd_decode.sv
hw/frame_execute.sv
hw/frame_result.sv
hw/frame_parser_top.sv
testbench/tb_frame_parser.sv

//--- hw/cmd_decode.sv
`timescale 1ns/1ps

// Command byte decode, purely combinational
module cmd_decode import frame_pkg::*; (
    input  cmd_fields_t cmd,
    output cmd_info_t   info
);

    logic               size_rsvd;
    logic [COUNT_W-1:0] beats;     // len + 1, at most 16

    assign size_rsvd = (cmd.size == 2'b11);
    assign beats     = COUNT_W'(cmd.len) + 1'b1;

    always_comb begin
        info.read   = cmd.rw;
        info.cmd_ok = !size_rsvd;  // Reserved size is the only illegal encoding

        // Reads carry no payload from the host
        // Reserved size is rejected later, so no payload is consumed either
        if (cmd.rw || size_rsvd) begin
            info.data_bytes = '0;
        end else begin
            info.data_bytes = beats << cmd.size; // 1, 2 or 4 bytes per beat
        end
    end

    // Sequencer relies on this to stay within the capture buffer
    always_comb begin
        a_count_max: assert final (info.data_bytes <= COUNT_W'(MAX_DATA_BYTES));
    end

endmodule

//--- hw/crc8_unit.sv
`timescale 1ns/1ps

// Running CRC-8 over the frame body (command, address and data bytes)
module crc8_unit import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              crc_clear,  // Start of a new frame
    input  logic              crc_en,     // Fold crc_byte in
    input  logic [BYTE_W-1:0] crc_byte,
    output logic [BYTE_W-1:0] crc_value
);

    // One byte through the shift register, MSB first, no reflection
    function automatic logic [BYTE_W-1:0] crc8_next(
        input logic [BYTE_W-1:0] crc,
        input logic [BYTE_W-1:0] din
    );
        logic [BYTE_W-1:0] c;
        c = crc ^ din;
        for (int i = 0; i < BYTE_W; i++) begin
            c = c[BYTE_W-1] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_value <= '0;
        end else if (crc_clear) begin
            crc_value <= '0;                            // Initial value is zero
        end else if (crc_en) begin
            crc_value <= crc8_next(crc_value, crc_byte);
        end
    end

    // The sequencer clears on the start byte and enables only on body bytes,
    // so the two strobes come from different states and never overlap
    a_clear_en_excl: assert property (
        @(posedge clk) disable iff (rst) !(crc_clear && crc_en)
    );

endmodule

//--- hw/frame_execute.sv
`timescale 1ns/1ps

// Byte sequencer: pops the show-ahead RX FIFO and captures the frame body
module frame_execute import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // Show-ahead RX FIFO
    input  logic [BYTE_W-1:0] rx_fifo_data,
    input  logic              rx_fifo_empty,
    output logic              rx_fifo_rd_en,

    input  cmd_info_t         info,           // Decode of frame.cmd
    input  logic              result_pending, // Previous report not yet consumed
    output frame_t            frame,

    // CRC unit control
    output logic              crc_clear,
    output logic              crc_en,
    output logic [BYTE_W-1:0] crc_byte,

    // Hand-off to the result stage
    output logic              check,
    output logic [BYTE_W-1:0] check_byte,

    output logic              parser_busy
);

    typedef enum logic [2:0] {
        ST_HUNT,
        ST_CMD,
        ST_ADDR0,
        ST_ADDR1,
        ST_ADDR2,
        ST_ADDR3,
        ST_DATA,
        ST_CRC
    } state_t;

    state_t state;

    logic                                  pop;
    logic                                  sof_hit;
    logic                                  body_byte; // Byte covered by the CRC
    cmd_fields_t                           cmd_q;
    logic [31:0]                           addr_q;
    logic [0:MAX_DATA_BYTES-1][BYTE_W-1:0] data_q;
    logic [COUNT_W-1:0]                    count_q;

    // Hunting is frozen while a report waits for the consumer
    assign pop       = !rx_fifo_empty && ((state != ST_HUNT) || !result_pending);
    assign sof_hit   = (state == ST_HUNT) && (rx_fifo_data == SOF_BYTE);
    assign body_byte = (state != ST_HUNT) && (state != ST_CRC);

    assign rx_fifo_rd_en = pop;
    assign crc_clear     = pop && sof_hit;
    assign crc_en        = pop && body_byte;
    assign crc_byte      = rx_fifo_data;

    assign parser_busy = (state != ST_HUNT) || result_pending;

    // Sequencer and counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_HUNT;
            count_q <= '0;
            check   <= 1'b0;
        end else begin
            check <= pop && (state == ST_CRC); // Result stage sees it one cycle later
            if (pop) begin
                unique case (state)
                    ST_HUNT: begin
                        if (sof_hit) begin
                            state   <= ST_CMD;
                            count_q <= '0;
                        end                        // Anything else is dropped
                    end
                    ST_CMD:   state <= ST_ADDR0;
                    ST_ADDR0: state <= ST_ADDR1;
                    ST_ADDR1: state <= ST_ADDR2;
                    ST_ADDR2: state <= ST_ADDR3;
                    ST_ADDR3: begin
                        // cmd_q is settled here, so info is valid
                        if (info.read || (info.data_bytes == '0)) begin
                            state <= ST_CRC;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        count_q <= count_q + 1'b1;
                        if (count_q + 1'b1 == info.data_bytes) begin
                            state <= ST_CRC;
                        end
                    end
                    ST_CRC:   state <= ST_HUNT;
                    default:  state <= ST_HUNT;
                endcase
            end
        end
    end

    // Captured fields
    always_ff @(posedge clk) begin
        if (pop) begin
            unique case (state)
                ST_CMD:   cmd_q         <= cmd_fields_t'(rx_fifo_data);
                ST_ADDR0: addr_q[7:0]   <= rx_fifo_data;  // LSB first
                ST_ADDR1: addr_q[15:8]  <= rx_fifo_data;
                ST_ADDR2: addr_q[23:16] <= rx_fifo_data;
                ST_ADDR3: addr_q[31:24] <= rx_fifo_data;
                ST_DATA:  data_q[count_q[COUNT_W-2:0]] <= rx_fifo_data;
                ST_CRC:   check_byte    <= rx_fifo_data;
                default:  ;
            endcase
        end
    end

    assign frame = '{cmd: cmd_q, addr: addr_q, data: data_q, data_count: count_q};

    // FIFO contract with the bridge
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst) rx_fifo_rd_en |-> !rx_fifo_empty
    );

    // Capture never runs past what the decoder asked for
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_DATA || state == ST_CRC) |-> (count_q <= info.data_bytes)
    );

endmodule

//--- hw/frame_parser_top.sv
`timescale 1ns/1ps

// Host-to-device frame parser for the UART bridge
module frame_parser_top import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    // Show-ahead RX FIFO
    input  logic [BYTE_W-1:0] rx_fifo_data,
    input  logic              rx_fifo_empty,
    output logic              rx_fifo_rd_en,

    // Parsed frame and report
    output frame_t            frame,
    output logic              frame_valid,
    output logic              frame_error,
    output status_t           error_status,
    input  logic              frame_consumed,
    output logic              parser_busy
);

    cmd_info_t         info;
    logic              crc_clear;
    logic              crc_en;
    logic [BYTE_W-1:0] crc_byte;
    logic [BYTE_W-1:0] crc_value;
    logic              check;
    logic [BYTE_W-1:0] check_byte;
    logic              result_pending;

    cmd_decode u_cmd_decode (
        .cmd  (frame.cmd),
        .info (info)
    );

    frame_execute u_frame_execute (
        .clk            (clk),
        .rst            (rst),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .info           (info),
        .result_pending (result_pending),
        .frame          (frame),
        .crc_clear      (crc_clear),
        .crc_en         (crc_en),
        .crc_byte       (crc_byte),
        .check          (check),
        .check_byte     (check_byte),
        .parser_busy    (parser_busy)
    );

    crc8_unit u_crc8_unit (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

    frame_result u_frame_result (
        .clk            (clk),
        .rst            (rst),
        .check          (check),
        .check_byte     (check_byte),
        .crc_value      (crc_value),
        .cmd_ok         (info.cmd_ok),
        .frame_consumed (frame_consumed),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .error_status   (error_status),
        .result_pending (result_pending)
    );

endmodule

//--- hw/frame_pkg.sv
// Shared constants and types for the host-to-device frame parser
package frame_pkg;

    // Byte level protocol constants
    localparam int BYTE_W = 8;                      // One UART character
    localparam logic [BYTE_W-1:0] SOF_BYTE = 8'hA5; // Host-to-device start of frame
    localparam logic [BYTE_W-1:0] CRC_POLY = 8'h07; // x^8 + x^2 + x + 1

    // Payload sizing
    localparam int MAX_DATA_BYTES = 64;             // 16 beats of 32 bits
    localparam int COUNT_W = 7;                     // Must hold the value 64 itself

    // Status codes reported back to the host
    typedef enum logic [7:0] {
        STATUS_OK      = 8'h00,
        STATUS_CRC_ERR = 8'h01,
        STATUS_CMD_INV = 8'h02
    } status_t;

    // Command byte layout, MSB first
    //   rw   : 1 = read, 0 = write
    //   inc  : address increment per beat
    //   size : 0 byte, 1 half, 2 word, 3 reserved
    //   len  : beat count minus one
    typedef struct packed {
        logic       rw;
        logic       inc;
        logic [1:0] size;
        logic [3:0] len;
    } cmd_fields_t;

    // Decoded view of the command byte
    typedef struct packed {
        logic               read;       // Read request, no payload follows
        logic [COUNT_W-1:0] data_bytes; // Payload bytes to expect on the wire
        logic               cmd_ok;     // Low for the reserved size
    } cmd_info_t;

    // Captured frame as handed to the consumer
    // Data is stored byte 0 first, i.e. in wire order
    typedef struct packed {
        cmd_fields_t                             cmd;
        logic [31:0]                             addr;       // Little endian on the wire
        logic [0:MAX_DATA_BYTES-1][BYTE_W-1:0]   data;
        logic [COUNT_W-1:0]                      data_count; // Bytes actually captured
    } frame_t;

endpackage

//--- hw/frame_result.sv
`timescale 1ns/1ps

// Frame check and status hold until the consumer takes the frame
module frame_result import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              check,          // CRC byte arrived
    input  logic [BYTE_W-1:0] check_byte,     // Received CRC
    input  logic [BYTE_W-1:0] crc_value,      // Computed CRC
    input  logic              cmd_ok,
    input  logic              frame_consumed,
    output logic              frame_valid,
    output logic              frame_error,
    output status_t           error_status,
    output logic              result_pending
);

    status_t status_next;

    // Command legality wins over CRC mismatch
    always_comb begin
        if (!cmd_ok) begin
            status_next = STATUS_CMD_INV;
        end else if (check_byte != crc_value) begin
            status_next = STATUS_CRC_ERR;
        end else begin
            status_next = STATUS_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_valid  <= 1'b0;
            frame_error  <= 1'b0;
            error_status <= STATUS_OK;
        end else if (check) begin
            error_status <= status_next;
            frame_valid  <= (status_next == STATUS_OK);
            frame_error  <= (status_next != STATUS_OK);
        end else if (frame_consumed) begin
            frame_valid  <= 1'b0;                    // Report released
            frame_error  <= 1'b0;
            error_status <= STATUS_OK;
        end
    end

    // Also covers the cycle between the CRC pop and the flag going up
    assign result_pending = frame_valid || frame_error || check;

    // Exactly one of the two flags reports a frame
    a_flags_excl: assert property (
        @(posedge clk) disable iff (rst) !(frame_valid && frame_error)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frame_parser -Mdir obj_dir -f all.f \
    && ./obj_dir/Vtb_frame_parser > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1
exit 0

//--- testbench/tb_frame_table.svh
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// One test frame per row
typedef struct packed {
    logic [3:0]  junk;     // Non-start bytes sent ahead of the start byte
    logic [7:0]  cmd;      // rw, inc, size, len
    logic [31:0] addr;
    logic [7:0]  seed;     // XOR mask over the LFSR data bytes
    logic        corrupt;  // Send an inverted CRC byte
    status_t     status;   // Expected report
    logic        gaps;     // Random empty cycles ahead of each byte
} test_row_t;

localparam int NUM_TESTS = 11;

localparam test_row_t TESTS [NUM_TESTS] = '{
    '{4'd0, 8'h45, 32'h1000_0040, 8'h00, 1'b0, STATUS_OK,      1'b0}, // Byte write, 6 bytes
    '{4'd0, 8'h53, 32'h2000_1002, 8'h3C, 1'b0, STATUS_OK,      1'b0}, // Half write, 8 bytes
    '{4'd0, 8'h6F, 32'h4000_0100, 8'hC3, 1'b0, STATUS_OK,      1'b0}, // Word write, full 64
    '{4'd0, 8'hE7, 32'h8000_0010, 8'h00, 1'b0, STATUS_OK,      1'b0}, // Read, no payload
    '{4'd0, 8'h61, 32'h0000_0F00, 8'h11, 1'b1, STATUS_CRC_ERR, 1'b0},
    '{4'd0, 8'h32, 32'h1234_5678, 8'h00, 1'b0, STATUS_CMD_INV, 1'b0}, // Size 3, good CRC
    '{4'd0, 8'h00, 32'h0BAD_F00C, 8'h77, 1'b0, STATUS_OK,      1'b0}, // Right behind size 3
    '{4'd3, 8'h57, 32'h0102_0304, 8'h00, 1'b0, STATUS_OK,      1'b0}, // Leading junk
    '{4'd0, 8'h63, 32'h6A6A_0000, 8'h5A, 1'b0, STATUS_OK,      1'b1}, // Gaps inside the frame
    '{4'd5, 8'hA0, 32'h0000_0004, 8'h00, 1'b1, STATUS_CRC_ERR, 1'b1},
    '{4'd2, 8'h7B, 32'h55AA_55AA, 8'h00, 1'b1, STATUS_CMD_INV, 1'b1}  // Legality beats CRC
};

`endif

//--- testbench/tb_frame_parser.sv
`timescale 1ns/1ps

module tb_frame_parser import frame_pkg::*; ();

    `include "tb_frame_table.svh"

    localparam int RESET_CYCLES    = 8;
    localparam int HOLD_CYCLES     = 4;                       // Report held, next frame queued
    localparam int WAIT_MAX        = (MAX_DATA_BYTES + 40) * 4; // Cycles per report
    localparam int WATCHDOG_CYCLES = NUM_TESTS * WAIT_MAX;
    localparam logic [31:0] LFSR_SEED = 32'h7067ef91;

    logic              clk = 1'b0;
    logic              rst;
    logic [BYTE_W-1:0] rx_fifo_data = '0;
    logic              rx_fifo_empty = 1'b1;
    logic              rx_fifo_rd_en;
    frame_t            frame;
    logic              frame_valid;
    logic              frame_error;
    status_t           error_status;
    logic              frame_consumed;
    logic              parser_busy;

    logic [BYTE_W-1:0] fifo_q[$];    // FIFO contents, head first
    int unsigned       gap_q[$];     // Empty cycles shown before each byte
    logic [31:0]       lfsr_state;
    int                exp_count [NUM_TESTS];
    logic [BYTE_W-1:0] exp_data [NUM_TESTS][MAX_DATA_BYTES];
    int                check_fails = 0;
    int                tests_passed = 0;

    frame_parser_top DUT (.*);

    always #5 clk = ~clk;            // 10 ns period

    // Show-ahead FIFO, head presented on the falling edge
    always @(negedge clk) begin
        if (fifo_q.size() == 0) begin
            rx_fifo_empty <= 1'b1;
        end else if (gap_q[0] != 0) begin
            gap_q[0] = gap_q[0] - 1;                   // Idle cycle on the link
            rx_fifo_empty <= 1'b1;
        end else begin
            rx_fifo_empty <= 1'b0;
            rx_fifo_data  <= fifo_q[0];
        end
    end

    // A byte leaves on the rising edge that sees rd_en
    always @(posedge clk) begin
        if (rx_fifo_rd_en) begin
            fifo_q.delete(0);
            gap_q.delete(0);
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);       // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Bit-serial CRC-8, poly 07, MSB first
    function automatic logic [7:0] crc8_ref(input logic [7:0] crc, input logic [7:0] d);
        logic [7:0] r;
        r = crc;
        for (int i = 7; i >= 0; i--) begin
            r = {r[6:0], 1'b0} ^ ((r[7] ^ d[i]) ? CRC_POLY : 8'h00);
        end
        return r;
    endfunction

    function automatic int expected_count(input logic [7:0] cmd);
        if (cmd[7] || (cmd[5:4] == 2'b11)) begin
            return 0;                                   // Reads and reserved size carry nothing
        end
        return (int'(cmd[3:0]) + 1) << cmd[5:4];
    endfunction

    task automatic push_byte(input logic [7:0] b, input logic gaps);
        logic [31:0] r;
        r = '0;
        if (gaps) begin
            draw_bits(2, r);                            // 0 to 3 empty cycles
        end
        fifo_q.push_back(b);
        gap_q.push_back(r[1:0]);
    endtask

    task automatic queue_frame(input int t);
        logic [31:0] r;
        logic [7:0]  crc;
        logic [7:0]  body[$];
        exp_count[t] = expected_count(TESTS[t].cmd);
        for (int j = 0; j < TESTS[t].junk; j++) begin
            draw_bits(8, r);
            push_byte((r[7:0] == SOF_BYTE) ? 8'h5A : r[7:0], TESTS[t].gaps); // Never a start
        end
        push_byte(SOF_BYTE, TESTS[t].gaps);
        body.push_back(TESTS[t].cmd);
        for (int k = 0; k < 4; k++) begin
            body.push_back(TESTS[t].addr[8*k +: 8]); // Little endian
        end
        for (int k = 0; k < exp_count[t]; k++) begin
            draw_bits(8, r);
            exp_data[t][k] = r[7:0] ^ TESTS[t].seed;
            body.push_back(exp_data[t][k]);
        end
        crc = 8'h00;
        foreach (body[k]) begin
            crc = crc8_ref(crc, body[k]);
            push_byte(body[k], TESTS[t].gaps);
        end
        push_byte(TESTS[t].corrupt ? ~crc : crc, TESTS[t].gaps);
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            check_fails++;
        end
    endtask

    task automatic wait_for_report(input int t);
        int cycles;
        cycles = 0;
        while (!(frame_valid || frame_error)) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_MAX) begin
                $display("Test %0d: the DUT raised no frame report in %0d cycles", t, cycles);
                $display("Some tests failed");
                $finish;
            end
        end
    endtask

    task automatic verify_report(input int t);
        frame_t held;
        logic   ok;
        ok = (TESTS[t].status == STATUS_OK);
        expect_true(frame_valid == ok && frame_error == !ok,
                    $sformatf("test %0d flags valid %b error %b", t, frame_valid, frame_error));
        expect_true(error_status == TESTS[t].status, $sformatf("test %0d status %02h, want %02h",
                    t, error_status, TESTS[t].status));
        expect_true(frame.cmd == TESTS[t].cmd, $sformatf("test %0d cmd %02h", t, frame.cmd));
        expect_true(frame.addr == TESTS[t].addr, $sformatf("test %0d addr %08h", t, frame.addr));
        expect_true(int'(frame.data_count) == exp_count[t],
                    $sformatf("test %0d data_count %0d, want %0d", t, frame.data_count, exp_count[t]));
        for (int k = 0; k < exp_count[t]; k++) begin
            expect_true(frame.data[k] == exp_data[t][k], $sformatf("test %0d data[%0d] %02h, want %02h",
                        t, k, frame.data[k], exp_data[t][k]));
        end
        held = frame;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            expect_true(frame_valid == ok && frame_error == !ok, "report dropped before consume");
            expect_true(parser_busy && !rx_fifo_rd_en, "parser not parked while report held");
            expect_true(frame == held, "frame changed while report held");
        end
    endtask

    task automatic release_report();
        frame_consumed = 1'b1;
        @(negedge clk);
        frame_consumed = 1'b0;
        expect_true(!frame_valid && !frame_error, "report still up after frame_consumed");
    endtask

    initial begin
        int fails_before;
        rst = 1'b1;
        frame_consumed = 1'b0;
        lfsr_state = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        expect_true(!rx_fifo_rd_en && !frame_valid && !frame_error && !parser_busy &&
                    error_status == STATUS_OK, "outputs not idle after reset");
        queue_frame(0);
        for (int t = 0; t < NUM_TESTS; t++) begin
            fails_before = check_fails;
            wait_for_report(t);
            if (t + 1 < NUM_TESTS) begin
                queue_frame(t + 1);                     // Lands while this report is held
            end
            verify_report(t);
            release_report();
            if (check_fails == fails_before) begin
                tests_passed++;
            end
            $display("Test %0d cmd %02h status %02h: %s", t, TESTS[t].cmd, TESTS[t].status,
                     (check_fails == fails_before) ? "pass" : "FAIL");
        end
        $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 NUM_TESTS, tests_passed, NUM_TESTS - tests_passed, check_fails);
        if (check_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule
